//--- include/uart_macros.svh
/* widths, register map and reset baud divisor for the UART controller */

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

// data bits per frame
`define UART_DW 8
// baud counter width
`define UART_CW 16
// bus address and data widths
`define UART_AW 2
`define UART_BW 16

////////////////////////////////////////
// register map
////////////////////////////////////////

`define UART_ADR_CFG 2'd0
`define UART_ADR_DAT 2'd1
`define UART_ADR_STS 2'd2

// divisor after reset, bit time is divisor+1 clocks
`define UART_BDR_RST 16'd86

`endif

//--- logic/uart_pkg.sv
/* bus request/response structs, write word union,
   receive byte and status word types */

`include "uart_macros.svh"

package uart_pkg;

  ////////////////////////////////////////
  // write word views
  ////////////////////////////////////////

  // data view, byte in the low bits
  typedef struct packed {
    logic [`UART_BW-`UART_DW-1:0] rsv;
    logic [`UART_DW-1:0]          dat;
  } word_dat_t;

  // one bus word, decoded by address
  typedef union packed {
    // whole word as baud divisor
    logic [`UART_BW-1:0] cfg_bdr;
    // byte for the transmitter
    word_dat_t           dat;
  } word_u;

  ////////////////////////////////////////
  // bus
  ////////////////////////////////////////

  typedef struct packed {
    logic                vld;
    logic                wen;
    logic [`UART_AW-1:0] adr;
    word_u               wdt;
  } bus_req_t;

  // fixed one cycle reply to reads
  typedef struct packed {
    logic                vld;
    logic [`UART_BW-1:0] rdt;
  } bus_rsp_t;

  ////////////////////////////////////////
  // receive path and status
  ////////////////////////////////////////

  // vld is a single cycle pulse, frm marks a bad stop bit
  typedef struct packed {
    logic                vld;
    logic [`UART_DW-1:0] dat;
    logic                frm;
  } rx_byte_t;

  // last member lands on bit 0
  typedef struct packed {
    logic [`UART_BW-5:0] rsv;
    logic                rx_ovr;
    logic                rx_frm;
    logic                rx_vld;
    logic                tx_rdy;
  } sts_t;

endpackage

//--- logic/uart_ser.sv
/* transmit serializer, start/data/stop framing of accepted bytes on txd */

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_ser (
  input  logic                clk,
  input  logic                rst,
  // baud divisor
  input  logic [`UART_CW-1:0] cfg_bdr,
  // byte stream in
  input  logic                str_vld,
  input  logic [`UART_DW-1:0] str_dat,
  output logic                str_rdy,
  // serial out
  output logic                txd
);

  // start + data + stop
  localparam int unsigned FW  = `UART_DW + 2;
  localparam int unsigned BCW = $clog2(FW + 1);

  logic                str_trn;
  logic [`UART_CW-1:0] bdr_lat;
  logic [`UART_CW-1:0] bdr_cnt;
  logic                bdr_end;
  logic [BCW-1:0]      bit_cnt;
  logic [FW-1:0]       shf_dat;

  ////////////////////////////////////////
  // stream handshake
  ////////////////////////////////////////

  assign str_trn = str_vld & str_rdy;
  // idle once every bit has gone out
  assign str_rdy = (bit_cnt == '0);

  ////////////////////////////////////////
  // baud timing
  ////////////////////////////////////////

  // divisor held for the whole frame
  always_ff @(posedge clk) begin
    if (str_trn) begin
      bdr_lat <= cfg_bdr;
    end
  end

  assign bdr_end = (bdr_cnt == bdr_lat);

  // counts 0..divisor per bit, parked at 0 while idle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bdr_cnt <= '0;
    end else if (str_trn) begin
      bdr_cnt <= '0;
    end else if (!str_rdy) begin
      if (bdr_end) begin
        bdr_cnt <= '0;
      end else begin
        bdr_cnt <= bdr_cnt + 1'b1;
      end
    end
  end

  // bits left in the frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (str_trn) begin
      bit_cnt <= BCW'(FW);
    end else if (!str_rdy && bdr_end) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////
  // shifter
  ////////////////////////////////////////

  // lsb first, ones shifted in keep the line at stop level
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shf_dat <= '1;
    end else if (str_trn) begin
      shf_dat <= {1'b1, str_dat, 1'b0};
    end else if (!str_rdy && bdr_end) begin
      shf_dat <= {1'b1, shf_dat[FW-1:1]};
    end
  end

  assign txd = shf_dat[0];

  // start bit on the line the cycle after a transfer, busy from then on
  a_trn_start: assert property (@(posedge clk) disable iff (rst)
    str_trn |=> (!txd && !str_rdy));

  // no frame in flight means an idle high line
  a_idle_high: assert property (@(posedge clk) disable iff (rst)
    str_rdy |-> txd);

endmodule

//--- logic/uart_des.sv
/* receive deserializer, rxd sync, start detect, mid-bit sampling
   and framing check */

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_des (
  input  logic                clk,
  input  logic                rst,
  // baud divisor
  input  logic [`UART_CW-1:0] cfg_bdr,
  // serial in
  input  logic                rxd,
  // received byte
  output uart_pkg::rx_byte_t  rx_byte
);

  localparam int unsigned BCW = $clog2(`UART_DW);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } state_t;

  state_t              state;
  logic                rxd_m;
  logic                rxd_s;
  logic                rxd_d;
  logic                rxd_fall;
  logic [`UART_CW-1:0] bdr_lat;
  logic [`UART_CW-1:0] bdr_cnt;
  logic                bdr_end;
  logic                bdr_half;
  logic [BCW-1:0]      bit_cnt;
  logic [`UART_DW-1:0] shf_dat;
  logic                stp_smp;
  logic                out_vld;
  logic [`UART_DW-1:0] out_dat;
  logic                out_frm;

  ////////////////////////////////////////
  // line sync and edge
  ////////////////////////////////////////

  // two flop sync, third flop for edge detect
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rxd_m <= 1'b1;
      rxd_s <= 1'b1;
      rxd_d <= 1'b1;
    end else begin
      rxd_m <= rxd;
      rxd_s <= rxd_m;
      rxd_d <= rxd_s;
    end
  end

  assign rxd_fall = rxd_d & ~rxd_s;

  ////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////

  // divisor frozen at the start edge
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && rxd_fall) begin
      bdr_lat <= cfg_bdr;
    end
  end

  assign bdr_end  = (bdr_cnt == bdr_lat);
  assign bdr_half = (bdr_cnt == (bdr_lat >> 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= ST_IDLE;
      bdr_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (rxd_fall) begin
            state   <= ST_START;
            bdr_cnt <= '0;
          end
        end
        // recheck at half a bit, a high line was a glitch
        ST_START: begin
          if (bdr_half) begin
            state   <= rxd_s ? ST_IDLE : ST_DATA;
            bdr_cnt <= '0;
            bit_cnt <= '0;
          end else begin
            bdr_cnt <= bdr_cnt + 1'b1;
          end
        end
        // one bit time between samples, mid-bit
        ST_DATA: begin
          if (bdr_end) begin
            bdr_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BCW'(`UART_DW - 1)) begin
              state <= ST_STOP;
            end
          end else begin
            bdr_cnt <= bdr_cnt + 1'b1;
          end
        end
        ST_STOP: begin
          if (bdr_end) begin
            state   <= ST_IDLE;
            bdr_cnt <= '0;
          end else begin
            bdr_cnt <= bdr_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // lsb arrives first, ends up at bit 0
  always_ff @(posedge clk) begin
    if (state == ST_DATA && bdr_end) begin
      shf_dat <= {rxd_s, shf_dat[`UART_DW-1:1]};
    end
  end

  ////////////////////////////////////////
  // byte out
  ////////////////////////////////////////

  // middle of the stop bit
  assign stp_smp = (state == ST_STOP) && bdr_end;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= stp_smp;
    end
  end

  always_ff @(posedge clk) begin
    if (stp_smp) begin
      out_dat <= shf_dat;
      out_frm <= ~rxd_s;
    end
  end

  assign rx_byte = '{vld: out_vld, dat: out_dat, frm: out_frm};

  // at most one byte per frame
  a_vld_pulse: assert property (@(posedge clk) disable iff (rst)
    rx_byte.vld |=> !rx_byte.vld);

endmodule

//--- logic/uart_regs.sv
/* register block, bus decode, divisor and receive registers,
   status and read response */

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_regs (
  input  logic                clk,
  input  logic                rst,
  // register bus
  input  uart_pkg::bus_req_t  req,
  output logic                bus_rdy,
  output uart_pkg::bus_rsp_t  rsp,
  // configuration
  output logic [`UART_CW-1:0] cfg_bdr,
  // to serializer
  output logic                tx_vld,
  output logic [`UART_DW-1:0] tx_dat,
  input  logic                tx_rdy,
  // from deserializer
  input  uart_pkg::rx_byte_t  rx_byte
);

  logic                is_cfg;
  logic                is_dat;
  logic                is_sts;
  logic                dat_wr;
  logic                trn;
  logic                wr_trn;
  logic                rd_trn;
  logic                rd_dat;
  logic                rd_sts;
  logic [`UART_DW-1:0] rx_dat;
  logic                rx_vld;
  logic                rx_frm;
  logic                rx_ovr;
  uart_pkg::sts_t      sts;
  logic [`UART_BW-1:0] rdt_mux;
  logic                rsp_vld;
  logic [`UART_BW-1:0] rsp_rdt;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  assign is_cfg = (req.adr == `UART_ADR_CFG);
  assign is_dat = (req.adr == `UART_ADR_DAT);
  assign is_sts = (req.adr == `UART_ADR_STS);

  // byte write, passed straight on to the serializer
  assign dat_wr = req.vld & req.wen & is_dat;
  assign tx_vld = dat_wr;
  assign tx_dat = req.wdt.dat.dat;

  // stall only a byte write while a frame is going out
  assign bus_rdy = ~dat_wr | tx_rdy;

  assign trn    = req.vld & bus_rdy;
  assign wr_trn = trn & req.wen;
  assign rd_trn = trn & ~req.wen;
  assign rd_dat = rd_trn & is_dat;
  assign rd_sts = rd_trn & is_sts;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // divisor, word read through the cfg view
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cfg_bdr <= `UART_BDR_RST;
    end else if (wr_trn && is_cfg) begin
      cfg_bdr <= req.wdt.cfg_bdr[`UART_CW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rx_byte.vld) begin
      rx_dat <= rx_byte.dat;
    end
  end

  // new byte beats a clear on the same cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_vld <= 1'b0;
      rx_ovr <= 1'b0;
      rx_frm <= 1'b0;
    end else begin
      if (rx_byte.vld) begin
        rx_vld <= 1'b1;
        // unread byte lost, unless it is being read right now
        rx_ovr <= (rx_vld | rx_ovr) & ~rd_dat;
      end else if (rd_dat) begin
        rx_vld <= 1'b0;
        rx_ovr <= 1'b0;
      end
      if (rx_byte.vld) begin
        rx_frm <= rx_byte.frm;
      end else if (rd_sts) begin
        rx_frm <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // read data and response
  ////////////////////////////////////////

  always_comb begin
    sts        = '0;
    sts.tx_rdy = tx_rdy;
    sts.rx_vld = rx_vld;
    sts.rx_frm = rx_frm;
    sts.rx_ovr = rx_ovr;
  end

  // address 3 reads as zero
  always_comb begin
    case (req.adr)
      `UART_ADR_CFG: rdt_mux = `UART_BW'(cfg_bdr);
      `UART_ADR_DAT: rdt_mux = `UART_BW'(rx_dat);
      `UART_ADR_STS: rdt_mux = sts;
      default:       rdt_mux = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= rd_trn;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_trn) begin
      rsp_rdt <= rdt_mux;
    end
  end

  assign rsp = '{vld: rsp_vld, rdt: rsp_rdt};

  // reply exactly one cycle after each read handshake on the bus ports
  a_rsp_follow: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (rsp.vld == $past(req.vld && !req.wen && bus_rdy)));

  // an accepted byte makes the serializer busy
  a_tx_busy: assert property (@(posedge clk) disable iff (rst)
    (tx_vld && tx_rdy) |=> !tx_rdy);

endmodule

//--- logic/uart_ctl.sv
/* UART controller top, register block with serializer and deserializer */

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_ctl (
  input  logic               clk,
  input  logic               rst,
  // register bus
  input  uart_pkg::bus_req_t req,
  output logic               bus_rdy,
  output uart_pkg::bus_rsp_t rsp,
  // serial lines
  output logic               txd,
  input  logic               rxd
);

  // shared divisor
  logic [`UART_CW-1:0] cfg_bdr;
  // transmit byte stream
  logic                tx_vld;
  logic [`UART_DW-1:0] tx_dat;
  logic                tx_rdy;
  // receive byte
  uart_pkg::rx_byte_t  rx_byte;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  uart_regs regs_i (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .bus_rdy (bus_rdy),
    .rsp     (rsp),
    .cfg_bdr (cfg_bdr),
    .tx_vld  (tx_vld),
    .tx_dat  (tx_dat),
    .tx_rdy  (tx_rdy),
    .rx_byte (rx_byte)
  );

  ////////////////////////////////////////
  // serial paths
  ////////////////////////////////////////

  uart_ser ser_i (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .str_vld (tx_vld),
    .str_dat (tx_dat),
    .str_rdy (tx_rdy),
    .txd     (txd)
  );

  uart_des des_i (
    .clk     (clk),
    .rst     (rst),
    .cfg_bdr (cfg_bdr),
    .rxd     (rxd),
    .rx_byte (rx_byte)
  );

endmodule

//--- tests/uart_ctl_tb.sv
/* UART controller testbench, bus tasks, loopback and driven rxd,
   reset, loopback, back-pressure, framing and overrun checks */

`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_ctl_tb;

  // bit time of 8 clocks on the test link
  localparam logic [`UART_CW-1:0] TB_BDR = 16'd7;
  localparam int FRM_CYC   = (`UART_DW + 2) * (int'(TB_BDR) + 1);
  localparam int TMO_CYC   = 4 * FRM_CYC;
  localparam int POLL_MAX  = 200;
  localparam int NUM_BYTES = 8;
  // status bit positions
  localparam logic [`UART_BW-1:0] M_TX_RDY = 16'h0001;
  localparam logic [`UART_BW-1:0] M_RX_VLD = 16'h0002;
  localparam logic [`UART_BW-1:0] M_RX_OVR = 16'h0008;

  logic               clk;
  logic               rst;
  uart_pkg::bus_req_t req;
  logic               bus_rdy;
  uart_pkg::bus_rsp_t rsp;
  logic               txd;
  logic               rxd;
  logic               lpb;
  logic               rxd_drv;
  logic               rd_acc;

  uart_ctl dut_i (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .bus_rdy (bus_rdy),
    .rsp     (rsp),
    .txd     (txd),
    .rxd     (rxd)
  );

  // loopback or line driven by the testbench
  assign rxd = lpb ? txd : rxd_drv;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [`UART_BW-1:0] exp,
                             input logic [`UART_BW-1:0] act);
    assert (act === exp)
    else stop_on_error($sformatf("error: time %0t, %s expected 0x%h, actual 0x%h",
                                 $time, name, exp, act));
  endtask

  // all bus tasks start and end 1 ns after a rising edge
  task automatic bus_write(input logic [`UART_AW-1:0] adr,
                           input logic [`UART_BW-1:0] wdt, output int stall);
    stall           = 0;
    req.vld         = 1'b1;
    req.wen         = 1'b1;
    req.adr         = adr;
    req.wdt.cfg_bdr = wdt;
    // bus_rdy only moves on clock edges, sample mid cycle
    @(negedge clk);
    while (!bus_rdy && stall < TMO_CYC) begin
      stall++;
      @(negedge clk);
    end
    if (!bus_rdy) stop_on_error("bus write never accepted, bus_rdy stayed low");
    @(posedge clk);
    #1;
    req = '0;
  endtask

  task automatic bus_read(input logic [`UART_AW-1:0] adr, output logic [`UART_BW-1:0] rdt);
    int cnt;
    cnt     = 0;
    req.vld = 1'b1;
    req.wen = 1'b0;
    req.adr = adr;
    req.wdt = '0;
    @(negedge clk);
    while (!bus_rdy && cnt < TMO_CYC) begin
      cnt++;
      @(negedge clk);
    end
    if (!bus_rdy) stop_on_error("bus read never accepted, bus_rdy stayed low");
    @(posedge clk);
    #1;
    req = '0;
    // reply due in the cycle after the accept
    cnt = 0;
    @(negedge clk);
    while (!rsp.vld && cnt < TMO_CYC) begin
      cnt++;
      @(negedge clk);
    end
    if (!rsp.vld) stop_on_error("no read response arrived");
    rdt = rsp.rdt;
    @(posedge clk);
    #1;
  endtask

  task automatic read_expect(input logic [`UART_AW-1:0] adr,
                             input logic [`UART_BW-1:0] exp, input string name);
    logic [`UART_BW-1:0] rdt;
    bus_read(adr, rdt);
    check_value(name, exp, rdt);
  endtask

  // STS reads until a flag in mask shows up
  task automatic poll_status(input logic [`UART_BW-1:0] mask, output uart_pkg::sts_t sts);
    logic [`UART_BW-1:0] rdt;
    int n;
    n   = 0;
    rdt = '0;
    while ((rdt & mask) == '0 && n < POLL_MAX) begin
      bus_read(`UART_ADR_STS, rdt);
      n++;
    end
    if ((rdt & mask) == '0) stop_on_error("status flag never set while polling STS");
    sts = rdt;
  endtask

  // start, data lsb first, then the given stop level
  task automatic drive_frame(input logic [`UART_DW-1:0] dat, input logic stp);
    logic [`UART_DW+1:0] bits;
    bits = {stp, dat, 1'b0};
    for (int i = 0; i < `UART_DW + 2; i++) begin
      rxd_drv = bits[i];
      repeat (int'(TB_BDR) + 1) @(posedge clk);
      #1;
    end
    rxd_drv = 1'b1;
  endtask

  ////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////

  assign rd_acc = req.vld & ~req.wen & bus_rdy;

  a_rsp_after_read: assert property (@(posedge clk) disable iff (rst) rd_acc |=> rsp.vld)
    else stop_on_error("read accepted but no response in the next cycle");

  a_rsp_only_read: assert property (@(posedge clk) disable iff (rst) !rd_acc |=> !rsp.vld)
    else stop_on_error("response seen without an accepted read");

  // idle transmitter keeps the line high
  a_txd_idle: assert property (@(posedge clk) disable iff (rst)
    (txd && dut_i.tx_rdy && !dut_i.tx_vld) |=> txd)
    else stop_on_error("txd left the idle level while no byte was being sent");

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    logic [`UART_BW-1:0] rdt;
    uart_pkg::sts_t      sts;
    logic [`UART_DW-1:0] b0;
    logic [`UART_DW-1:0] b1;
    int                  stall;
    void'($urandom(32'h2bf371b0));
    rst     = 1'b1;
    req     = '0;
    lpb     = 1'b1;
    rxd_drv = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // reset values
    check_value("txd", `UART_BW'(1), `UART_BW'(txd));
    check_value("bus_rdy", `UART_BW'(1), `UART_BW'(bus_rdy));
    read_expect(`UART_ADR_STS, M_TX_RDY, "sts");
    read_expect(`UART_ADR_CFG, `UART_BDR_RST, "cfg");
    read_expect(2'd3, '0, "rdt at address 3");

    // new divisor, then random bytes around the loop
    bus_write(`UART_ADR_CFG, TB_BDR, stall);
    read_expect(`UART_ADR_CFG, TB_BDR, "cfg");
    for (int i = 0; i < NUM_BYTES; i++) begin
      b0 = `UART_DW'($urandom());
      bus_write(`UART_ADR_DAT, `UART_BW'(b0), stall);
      poll_status(M_RX_VLD, sts);
      check_value("sts.rx_frm", '0, `UART_BW'(sts.rx_frm));
      check_value("sts.rx_ovr", '0, `UART_BW'(sts.rx_ovr));
      read_expect(`UART_ADR_DAT, `UART_BW'(b0), "dat");
      bus_read(`UART_ADR_STS, rdt);
      sts = rdt;
      check_value("sts.rx_vld", '0, `UART_BW'(sts.rx_vld));
    end

    // back-to-back writes, second one stalls for a whole frame
    poll_status(M_TX_RDY, sts);
    b0 = `UART_DW'($urandom());
    b1 = `UART_DW'($urandom());
    bus_write(`UART_ADR_DAT, `UART_BW'(b0), stall);
    check_value("bus_rdy stall cycles, first write", '0, `UART_BW'(stall));
    bus_write(`UART_ADR_DAT, `UART_BW'(b1), stall);
    check_value("bus_rdy stall cycles, second write", `UART_BW'(FRM_CYC), `UART_BW'(stall));

    // both bytes land unread, so overrun
    poll_status(M_RX_OVR, sts);
    check_value("sts.rx_vld", `UART_BW'(1), `UART_BW'(sts.rx_vld));
    read_expect(`UART_ADR_DAT, `UART_BW'(b1), "dat");
    bus_read(`UART_ADR_STS, rdt);
    sts = rdt;
    check_value("sts.rx_vld", '0, `UART_BW'(sts.rx_vld));
    check_value("sts.rx_ovr", '0, `UART_BW'(sts.rx_ovr));

    // bad stop bit on a driven line
    poll_status(M_TX_RDY, sts);
    lpb = 1'b0;
    b0  = `UART_DW'($urandom());
    drive_frame(b0, 1'b0);
    poll_status(M_RX_VLD, sts);
    check_value("sts.rx_frm", `UART_BW'(1), `UART_BW'(sts.rx_frm));
    // STS read above clears the flag
    bus_read(`UART_ADR_STS, rdt);
    sts = rdt;
    check_value("sts.rx_frm", '0, `UART_BW'(sts.rx_frm));
    read_expect(`UART_ADR_DAT, `UART_BW'(b0), "dat");
    lpb = 1'b1;

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- uart_ctl.f
+incdir+include
logic/uart_pkg.sv
logic/uart_ser.sv
logic/uart_des.sv
logic/uart_regs.sv
logic/uart_ctl.sv
tests/uart_ctl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the UART controller testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=uart_ctl_tb

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -Mdir "$BUILD_DIR" -f uart_ctl.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

SIM_OUT=$("./$BUILD_DIR/V$TOP" 2>&1)
SIM_STATUS=$?
echo "$SIM_OUT"
if [ $SIM_STATUS -ne 0 ]; then
  echo "simulation exited with status $SIM_STATUS"
  exit 1
fi

if echo "$SIM_OUT" | grep -qx "STATUS: PASS"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
